// ==== bk_adder_top.f ====
+incdir+hw
hw/bk_adder_pkg.sv
hw/bk_prefix_tree.sv
hw/bk_adder_core.sv
hw/bk_sync_fifo.sv
hw/bk_apb_regs.sv
hw/bk_adder_top.sv
bench/bk_clk_gen.sv
bench/bk_adder_tb.sv

// ==== Bender.yml ====
package:
  name: bk_adder

sources:
  - include_dirs:
      - hw
    files:
      - hw/bk_adder_pkg.sv
      - hw/bk_prefix_tree.sv
      - hw/bk_adder_core.sv
      - hw/bk_sync_fifo.sv
      - hw/bk_apb_regs.sv
      - hw/bk_adder_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - bench/bk_clk_gen.sv
      - bench/bk_adder_tb.sv

// ==== bench/bk_adder_tb.sv ====
`timescale 1ns/10ps

`include "bk_adder_params.svh"

module bk_adder_tb;

    localparam int MAX_CYCLES = 4000;  // About four times the longest run

    logic                  clk;
    logic                  arst_n;
    logic [`BK_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  chk_err;
    logic                  exp_err;
    logic                  chk_result;
    logic [31:0]           exp_data;
    logic                  chk_status;
    logic [4:0]            exp_status;
    logic [31:0]           exp_q [$];  // Expected RESULT words in issue order
    int                    err_count;
    int                    check_count;
    int                    tests_passed;
    int                    tests_failed;
    int                    test_errs;
    int                    cycle_count;

    bk_clk_gen bk_clk_gen_inst (.clk(clk), .arst_n(arst_n));

    bk_adder_top bk_adder_top_inst (
        .clk(clk), .arst_n(arst_n), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    assert property (@(posedge clk) disable iff (!arst_n) pready == 1'b1)
        else begin
            $display("Fail pready = 0x%h, expected 0x1", $sampled(pready));
            err_count++;
        end

    assert property (@(posedge clk) disable iff (!arst_n) !(psel && penable) |-> !pslverr)
        else begin
            $display("Fail pslverr = 0x%h outside an access, expected 0x0", $sampled(pslverr));
            err_count++;
        end

    assert property (@(posedge clk) disable iff (!arst_n)
        psel && penable && chk_err |-> pslverr == exp_err)
        else begin
            $display("Fail pslverr = 0x%h, expected 0x%h", $sampled(pslverr), $sampled(exp_err));
            err_count++;
        end

    assert property (@(posedge clk) disable iff (!arst_n)
        psel && penable && chk_result |-> prdata == exp_data)
        else begin
            $display("Fail prdata = 0x%h, expected 0x%h", $sampled(prdata), $sampled(exp_data));
            err_count++;
        end

    assert property (@(posedge clk) disable iff (!arst_n)
        psel && penable && chk_status |-> prdata[4:0] == exp_status)
        else begin
            $display("Fail prdata[4:0] = 0x%h, expected 0x%h",
                     $sampled(prdata[4:0]), $sampled(exp_status));
            err_count++;
        end

    // Reference model is plain addition with cout in bit 26
    function automatic logic [31:0] model_add(input logic [25:0] a, input logic [25:0] b,
                                              input logic cin);
        longint total;
        total = longint'(a) + longint'(b) + longint'(cin);
        return 32'(total);
    endfunction

    task automatic apb_xfer(input logic wr, input logic [`BK_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        rdata = prdata;  // Still the pre-edge value here
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [`BK_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic want_err);
        logic [31:0] unused;
        chk_err = 1'b1;
        exp_err = want_err;
        check_count++;
        apb_xfer(1'b1, addr, data, unused);
        chk_err = 1'b0;
    endtask

    task automatic apb_read(input logic [`BK_ADDR_W-1:0] addr, output logic [31:0] data,
                            input logic want_err);
        chk_err = 1'b1;
        exp_err = want_err;
        check_count++;
        apb_xfer(1'b0, addr, 32'h0, data);
        chk_err = 1'b0;
    endtask

    task automatic check_status(input logic [4:0] want);
        logic [31:0] st;
        exp_status = want;
        chk_status = 1'b1;
        check_count++;
        apb_read(`BK_REG_STATUS, st, 1'b0);
        chk_status = 1'b0;
    endtask

    task automatic issue_op(input logic [25:0] a, input logic [25:0] b, input logic cin,
                            input logic want_err);
        apb_write(`BK_REG_OP_A, 32'(a), 1'b0);
        apb_write(`BK_REG_OP_B, 32'(b), 1'b0);
        apb_write(`BK_REG_CTRL, 32'(cin), want_err);
        if (!want_err)
            exp_q.push_back(model_add(a, b, cin));
    endtask

    task automatic wait_result();
        logic [31:0] st;
        do
            apb_read(`BK_REG_STATUS, st, 1'b0);
        while (st[1]);  // Bit 1 is result FIFO empty
    endtask

    task automatic read_result();
        logic [31:0] rd;
        logic        empty;
        empty = (exp_q.size() == 0);
        exp_data = empty ? 32'h0 : exp_q.pop_front();
        chk_result = 1'b1;
        check_count++;
        apb_read(`BK_REG_RESULT, rd, empty);
        chk_result = 1'b0;
    endtask

    task automatic finish_test(input string name);
        if (err_count == test_errs) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, err_count - test_errs);
        end
        test_errs = err_count;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] st;
        int          n;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        chk_err = 1'b0;
        exp_err = 1'b0;
        chk_result = 1'b0;
        exp_data = '0;
        chk_status = 1'b0;
        exp_status = '0;
        err_count = 0;
        check_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_errs = 0;
        void'($urandom(72));
        @(posedge arst_n);
        @(negedge clk);

        check_status(5'b00010);  // Results empty, ops not full, count 0
        finish_test("reset state");

        repeat (50) begin
            issue_op(26'($urandom()), 26'($urandom()), 1'($urandom()), 1'b0);
            wait_result();
            read_result();
        end
        finish_test("random operations");

        issue_op(26'h3FFFFFF, 26'h0000001, 1'b0, 1'b0);
        issue_op(26'h3FFFFFF, 26'h3FFFFFF, 1'b1, 1'b0);
        issue_op(26'h2AAAAAA, 26'h1555555, 1'b1, 1'b0);  // Carry ripples the full width
        issue_op(26'h2AAAAAA, 26'h2AAAAAA, 1'b0, 1'b0);
        issue_op(26'h1555555, 26'h1555555, 1'b1, 1'b0);
        issue_op(26'h0000000, 26'h0000000, 1'b1, 1'b0);
        while (exp_q.size() != 0) begin
            wait_result();
            read_result();
        end
        finish_test("carry corner cases");

        // Fill both FIFOs and the core until the op FIFO reports full
        n = 0;
        st = '0;
        while (!st[0]) begin
            if (n == 16) begin
                $display("Operation FIFO never reported full after %0d writes", n);
                err_count++;
                break;
            end
            issue_op(26'($urandom()), 26'($urandom()), 1'($urandom()), 1'b0);
            n++;
            apb_read(`BK_REG_STATUS, st, 1'b0);
        end
        check_status(5'b10001);  // Four results held, op FIFO full
        issue_op(26'($urandom()), 26'($urandom()), 1'b0, 1'b1);
        repeat (n) begin
            wait_result();
            read_result();
        end
        finish_test("back-pressure and full FIFO");

        read_result();  // Queue is empty so an error and zero are expected
        issue_op(26'h0ABCDEF, 26'h3123456, 1'b1, 1'b0);
        wait_result();
        read_result();
        finish_test("empty result read");

        $display("Tests passed: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests_passed, tests_failed, check_count, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== bench/bk_clk_gen.sv ====
`timescale 1ns/10ps

module bk_clk_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;  // Released away from the rising edge
    end

endmodule

// ==== hw/bk_adder_top.sv ====
`timescale 1ns/10ps

`include "bk_adder_params.svh"

module bk_adder_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [`BK_ADDR_W-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr
);

    import bk_adder_pkg::*;

    bk_op_t     op_push_data;
    bk_op_t     op_pop_data;
    logic       op_push_valid;
    logic       op_push_ready;
    logic       op_pop_valid;
    logic       op_pop_ready;
    bk_res_t    res_push_data;
    bk_res_t    res_pop_data;
    logic       res_push_valid;
    logic       res_push_ready;
    logic       res_pop_valid;
    logic       res_pop_ready;
    logic [2:0] res_count;

    bk_apb_regs bk_apb_regs_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .op_valid  (op_push_valid),
        .op_ready  (op_push_ready),
        .op        (op_push_data),
        .res_valid (res_pop_valid),
        .res_ready (res_pop_ready),
        .res       (res_pop_data),
        .res_count (res_count)
    );

    bk_sync_fifo #(.payload_t(bk_op_t)) op_fifo (
        .clk        (clk),
        .arst_n     (arst_n),
        .push_valid (op_push_valid),
        .push_ready (op_push_ready),
        .push_data  (op_push_data),
        .pop_valid  (op_pop_valid),
        .pop_ready  (op_pop_ready),
        .pop_data   (op_pop_data),
        .count      ()
    );

    bk_adder_core bk_adder_core_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (op_pop_valid),
        .in_ready  (op_pop_ready),
        .in_op     (op_pop_data),
        .out_valid (res_push_valid),
        .out_ready (res_push_ready),
        .out_res   (res_push_data)
    );

    bk_sync_fifo #(.payload_t(bk_res_t)) res_fifo (
        .clk        (clk),
        .arst_n     (arst_n),
        .push_valid (res_push_valid),
        .push_ready (res_push_ready),
        .push_data  (res_push_data),
        .pop_valid  (res_pop_valid),
        .pop_ready  (res_pop_ready),
        .pop_data   (res_pop_data),
        .count      (res_count)
    );

endmodule

// ==== hw/bk_apb_regs.sv ====
`timescale 1ns/10ps

`include "bk_adder_params.svh"

module bk_apb_regs (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`BK_ADDR_W-1:0]  paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   op_valid,
    input  logic                   op_ready,
    output bk_adder_pkg::bk_op_t   op,
    input  logic                   res_valid,
    output logic                   res_ready,
    input  bk_adder_pkg::bk_res_t  res,
    input  logic [2:0]             res_count
);

    logic                 access;
    logic                 wr_en;
    logic                 rd_en;
    logic [`BK_WIDTH-1:0] op_a;
    logic [`BK_WIDTH-1:0] op_b;

    assign access = psel & penable;  // Access phase only
    assign wr_en  = access & pwrite;
    assign rd_en  = access & ~pwrite;
    assign pready = 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_a <= '0;
            op_b <= '0;
        end else if (wr_en) begin
            if (paddr == `BK_REG_OP_A)
                op_a <= pwdata[`BK_WIDTH-1:0];
            if (paddr == `BK_REG_OP_B)
                op_b <= pwdata[`BK_WIDTH-1:0];
        end
    end

    // CTRL write pushes straight into the op FIFO
    assign op_valid  = wr_en & (paddr == `BK_REG_CTRL);
    assign op        = '{a: op_a, b: op_b, cin: pwdata[0]};
    assign res_ready = rd_en & (paddr == `BK_REG_RESULT);

    always_comb begin
        prdata = '0;
        if (rd_en) begin
            case (paddr)
                `BK_REG_STATUS: begin
                    prdata[4:0] = {res_count, ~res_valid, ~op_ready};
                end
                `BK_REG_RESULT: begin
                    if (res_valid)
                        prdata[`BK_WIDTH:0] = {res.cout, res.sum};
                end
                default: prdata = '0;  // Unmapped reads as zero
            endcase
        end
    end

    assign pslverr = (op_valid & ~op_ready) | (res_ready & ~res_valid);

    assert property (@(posedge clk) disable iff (!arst_n)
        penable |-> psel)
        else $error("APB penable without psel");

endmodule

// ==== hw/bk_sync_fifo.sv ====
`timescale 1ns/10ps

`include "bk_adder_params.svh"

module bk_sync_fifo #(
    parameter type payload_t = logic
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       push_valid,
    output logic       push_ready,
    input  payload_t   push_data,
    output logic       pop_valid,
    input  logic       pop_ready,
    output payload_t   pop_data,
    output logic [2:0] count
);

    localparam int PTR_W = $clog2(`BK_FIFO_DEPTH);

    payload_t         mem [`BK_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign push_ready = (count != 3'(`BK_FIFO_DEPTH));
    assign pop_valid  = (count != 3'd0);
    assign do_push    = push_valid & push_ready;
    assign do_pop     = pop_valid & pop_ready;
    assign pop_data   = mem[rd_ptr];  // Head shown without a register

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(`BK_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(`BK_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 3'd1;
            else if (do_pop && !do_push)
                count <= count - 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        count <= 3'(`BK_FIFO_DEPTH))
        else $error("fifo count out of range");

    assert property (@(posedge clk) disable iff (!arst_n)
        pop_valid && !pop_ready |=> $stable(pop_data))
        else $error("fifo head changed while waiting");

endmodule

// ==== hw/bk_adder_core.sv ====
`timescale 1ns/10ps

`include "bk_adder_params.svh"

module bk_adder_core (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  bk_adder_pkg::bk_op_t  in_op,
    output logic                  out_valid,
    input  logic                  out_ready,
    output bk_adder_pkg::bk_res_t out_res
);

    logic [`BK_WIDTH:1] s1_p;
    logic [`BK_WIDTH:1] s1_g;
    logic               s1_cin;
    logic               s1_valid;
    logic [`BK_WIDTH:1] g_fold;
    logic [`BK_WIDTH:1] gg;
    logic [`BK_WIDTH:1] carry;
    logic               advance;

    assign advance  = ~out_valid | out_ready;  // Whole pipe holds on a stalled output
    assign in_ready = advance;

    assign g_fold = {s1_g[`BK_WIDTH:2], s1_g[1] | (s1_p[1] & s1_cin)};
    assign carry  = {gg[`BK_WIDTH-1:1], s1_cin};  // Carry into each bit

    bk_prefix_tree bk_prefix_tree_inst (
        .p  (s1_p),
        .g  (g_fold),
        .gp (),
        .gg (gg)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && in_valid) begin
            s1_p   <= in_op.a ^ in_op.b;
            s1_g   <= in_op.a & in_op.b;
            s1_cin <= in_op.cin;
        end
        if (advance && s1_valid) begin
            out_res.sum  <= s1_p ^ carry;
            out_res.cout <= gg[`BK_WIDTH];
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> !$isunknown(out_res))
        else $error("adder result unknown while offered");

endmodule

// ==== hw/bk_prefix_tree.sv ====
`timescale 1ns/10ps

`include "bk_adder_params.svh"

module bk_prefix_tree (
    input  logic [`BK_WIDTH:1] p,
    input  logic [`BK_WIDTH:1] g,
    output logic [`BK_WIDTH:1] gp,
    output logic [`BK_WIDTH:1] gg
);

    logic [`BK_WIDTH:1] p_l1, g_l1;
    logic [`BK_WIDTH:1] p_l2, g_l2;
    logic [`BK_WIDTH:1] p_l3, g_l3;
    logic [`BK_WIDTH:1] p_l4, g_l4;
    logic [`BK_WIDTH:1] p_l5, g_l5;
    logic [`BK_WIDTH:1] p_l6, g_l6;
    logic [`BK_WIDTH:1] p_l7, g_l7;

    generate
        for (genvar i = 1; i <= `BK_WIDTH; i++) begin : gen_up_l1
            if (i % 2 == 0) begin : gen_node
                assign p_l1[i] = p[i-1] & p[i];
                assign g_l1[i] = g[i] | (g[i-1] & p[i]);
            end else begin : gen_pass
                assign p_l1[i] = p[i];
                assign g_l1[i] = g[i];
            end
        end
        for (genvar i = 1; i <= `BK_WIDTH; i++) begin : gen_up_l2
            if (i % 4 == 0) begin : gen_node
                assign p_l2[i] = p_l1[i-2] & p_l1[i];
                assign g_l2[i] = g_l1[i] | (g_l1[i-2] & p_l1[i]);
            end else begin : gen_pass
                assign p_l2[i] = p_l1[i];
                assign g_l2[i] = g_l1[i];
            end
        end
        for (genvar i = 1; i <= `BK_WIDTH; i++) begin : gen_up_l3
            if (i % 8 == 0) begin : gen_node
                assign p_l3[i] = p_l2[i-4] & p_l2[i];
                assign g_l3[i] = g_l2[i] | (g_l2[i-4] & p_l2[i]);
            end else begin : gen_pass
                assign p_l3[i] = p_l2[i];
                assign g_l3[i] = g_l2[i];
            end
        end
        for (genvar i = 1; i <= `BK_WIDTH; i++) begin : gen_up_l4
            if (i % 16 == 0) begin : gen_node
                assign p_l4[i] = p_l3[i-8] & p_l3[i];
                assign g_l4[i] = g_l3[i] | (g_l3[i-8] & p_l3[i]);
            end else begin : gen_pass
                assign p_l4[i] = p_l3[i];
                assign g_l4[i] = g_l3[i];
            end
        end
        // Down-sweep fills in the remaining prefixes
        for (genvar i = 1; i <= `BK_WIDTH; i++) begin : gen_dn_l5
            if (i >= 24 && (i - 24) % 16 == 0) begin : gen_node
                assign p_l5[i] = p_l4[i-8] & p_l4[i];
                assign g_l5[i] = g_l4[i] | (g_l4[i-8] & p_l4[i]);
            end else begin : gen_pass
                assign p_l5[i] = p_l4[i];
                assign g_l5[i] = g_l4[i];
            end
        end
        for (genvar i = 1; i <= `BK_WIDTH; i++) begin : gen_dn_l6
            if (i >= 12 && (i - 12) % 8 == 0) begin : gen_node
                assign p_l6[i] = p_l5[i-4] & p_l5[i];
                assign g_l6[i] = g_l5[i] | (g_l5[i-4] & p_l5[i]);
            end else begin : gen_pass
                assign p_l6[i] = p_l5[i];
                assign g_l6[i] = g_l5[i];
            end
        end
        for (genvar i = 1; i <= `BK_WIDTH; i++) begin : gen_dn_l7
            if (i >= 6 && (i - 6) % 4 == 0) begin : gen_node
                assign p_l7[i] = p_l6[i-2] & p_l6[i];
                assign g_l7[i] = g_l6[i] | (g_l6[i-2] & p_l6[i]);
            end else begin : gen_pass
                assign p_l7[i] = p_l6[i];
                assign g_l7[i] = g_l6[i];
            end
        end
        for (genvar i = 1; i <= `BK_WIDTH; i++) begin : gen_dn_l8
            if (i >= 3 && (i - 3) % 2 == 0) begin : gen_node  // Odd positions last
                assign gp[i] = p_l7[i-1] & p_l7[i];
                assign gg[i] = g_l7[i] | (g_l7[i-1] & p_l7[i]);
            end else begin : gen_pass
                assign gp[i] = p_l7[i];
                assign gg[i] = g_l7[i];
            end
        end
    endgenerate

endmodule

// ==== hw/bk_adder_pkg.sv ====
`include "bk_adder_params.svh"

package bk_adder_pkg;

    // One queued add request
    typedef struct packed {
        logic [`BK_WIDTH-1:0] a;
        logic [`BK_WIDTH-1:0] b;
        logic                 cin;
    } bk_op_t;

    // One finished add
    typedef struct packed {
        logic [`BK_WIDTH-1:0] sum;
        logic                 cout;
    } bk_res_t;

endpackage

// ==== hw/bk_adder_params.svh ====
`ifndef BK_ADDER_PARAMS_SVH
`define BK_ADDER_PARAMS_SVH

`define BK_WIDTH      26
`define BK_FIFO_DEPTH 4
`define BK_ADDR_W     8

// APB register map
`define BK_REG_OP_A   8'h00
`define BK_REG_OP_B   8'h04
`define BK_REG_CTRL   8'h08
`define BK_REG_STATUS 8'h0C
`define BK_REG_RESULT 8'h10

`endif
